//--- bench/cv_ctrl_tb.sv
// Testbench for the controller-input top level.
// Applies a table of joystick words, swap, PS/2 events and select strobes,
// then checks the port lines and fire lines of both players.
// Random joystick rows follow the fixed table, seeded for repeatable runs.

`include "cv_ctrl_macros.svh"

module cv_ctrl_tb;

        timeunit 1ns;
        timeprecision 1ps;

        typedef struct packed {
                logic [31:0] joy0;
                logic [31:0] joy1;
                logic        swap;
                logic        ev;
                logic [7:0]  code;
                logic        press;
                logic [1:0]  kp_n;
                logic [1:0]  js_n;
                logic [3:0]  lines0;
                logic        fire0;
                logic [3:0]  lines1;
                logic        fire1;
        } row_t;

        logic                     clk_sys;
        logic                     rst_n_i;
        cv_ctrl_pkg::joy_word_t   joy0_i;
        cv_ctrl_pkg::joy_word_t   joy1_i;
        logic                     swap_i;
        cv_ctrl_pkg::ps2_key_t    ps2_key_i;
        logic [1:0]               kp_sel_n_i;
        logic [1:0]               js_sel_n_i;
        cv_ctrl_pkg::port_lines_t pad0_lines_o;
        logic                     pad0_fire_n_o;
        cv_ctrl_pkg::port_lines_t pad1_lines_o;
        logic                     pad1_fire_n_o;

        row_t  rows[$];
        string names[$];
        int    errors;
        int    checks;
        int    seed;
        logic  ps2_tog;

        // Keypad priority order, host bit and port code per entry
        logic [4:0] host_bit [0:13] = '{5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd13, 5'd14,
                                        5'd15, 5'd16, 5'd17, 5'd6, 5'd7, 5'd18, 5'd19};
        logic [3:0] entry_code [0:13] = '{`CV_KEY_0, `CV_KEY_1, `CV_KEY_2, `CV_KEY_3,
                                          `CV_KEY_4, `CV_KEY_5, `CV_KEY_6, `CV_KEY_7,
                                          `CV_KEY_8, `CV_KEY_9, `CV_KEY_STAR,
                                          `CV_KEY_NUMBER, `CV_KEY_PURPLE, `CV_KEY_BLUE};

        cv_ctrl_top dut0 (
                .clk_sys       (clk_sys),
                .rst_n_i       (rst_n_i),
                .joy0_i        (joy0_i),
                .joy1_i        (joy1_i),
                .swap_i        (swap_i),
                .ps2_key_i     (ps2_key_i),
                .kp_sel_n_i    (kp_sel_n_i),
                .js_sel_n_i    (js_sel_n_i),
                .pad0_lines_o  (pad0_lines_o),
                .pad0_fire_n_o (pad0_fire_n_o),
                .pad1_lines_o  (pad1_lines_o),
                .pad1_fire_n_o (pad1_fire_n_o)
        );

        initial begin
                clk_sys = 1'b0;
                forever #50 clk_sys = ~clk_sys;
        end

        // Reset held for 10 cycles, released on a falling edge
        initial begin
                rst_n_i = 1'b0;
                repeat (10) @(posedge clk_sys);
                @(negedge clk_sys);
                rst_n_i = 1'b1;
        end

        // ==============================
        // Table helpers
        // ==============================
        task automatic add_row(input string name, input logic [31:0] j0,
                               input logic [31:0] j1, input logic sw, input logic ev,
                               input logic [7:0] code, input logic press,
                               input logic [1:0] kp_n, input logic [1:0] js_n,
                               input logic [3:0] l0, input logic f0,
                               input logic [3:0] l1, input logic f1);
                row_t r;
                r.joy0   = j0;
                r.joy1   = j1;
                r.swap   = sw;
                r.ev     = ev;
                r.code   = code;
                r.press  = press;
                r.kp_n   = kp_n;
                r.js_n   = js_n;
                r.lines0 = l0;
                r.fire0  = f0;
                r.lines1 = l1;
                r.fire1  = f1;
                rows.push_back(r);
                names.push_back(name);
        endtask

        // Port lines and fire of one player from its host joystick word
        function automatic logic [4:0] expect_port(input logic [31:0] w, input logic kp_n,
                                                   input logic js_n);
                logic [3:0] kp_lines;
                logic [3:0] js_lines;
                logic       kp_fire;
                logic       js_fire;
                logic       found;
                kp_lines = `CV_KEY_NONE;
                kp_fire  = 1'b1;
                js_lines = 4'b1111;
                js_fire  = 1'b1;
                found    = 1'b0;
                if (!kp_n) begin
                        for (int p = 0; p < `CV_KEYPAD_KEYS; p++) begin
                                if (!found && w[host_bit[p]]) begin
                                        kp_lines = entry_code[p];
                                        found    = 1'b1;
                                end
                        end
                        kp_fire = ~w[5];
                end
                if (!js_n) begin
                        // Up on line 3, then right, down, left
                        js_lines = ~{w[3], w[0], w[2], w[1]};
                        js_fire  = ~w[4];
                end
                return {kp_lines & js_lines, kp_fire & js_fire};
        endfunction

        task automatic add_random_rows(input int count);
                logic [31:0] j0;
                logic [31:0] j1;
                logic [31:0] r;
                logic [4:0]  p0;
                logic [4:0]  p1;
                for (int n = 0; n < count; n++) begin
                        // Three words ANDed keep the key bits sparse
                        j0 = $random(seed) & $random(seed) & $random(seed);
                        j1 = $random(seed) & $random(seed) & $random(seed);
                        r  = $random(seed);
                        p0 = expect_port(r[0] ? j1 : j0, r[1], r[3]);
                        p1 = expect_port(r[0] ? j0 : j1, r[2], r[4]);
                        add_row($sformatf("random_%0d", n), j0, j1, r[0], 1'b0, 8'h00, 1'b0,
                                r[2:1], r[4:3], p0[4:1], p0[0], p1[4:1], p1[0]);
                end
        endtask

        task automatic build_table();
                add_row("reset_idle", 32'h0, 32'h0, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b11, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("reset_kp_sel", 32'h0, 32'h0, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("reset_js_sel", 32'h0, 32'h0, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b11, 2'b00, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("reset_both_sel", 32'h0, 32'h0, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b00, 2'b00, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("kp_keys_3_7", 32'h0000_8800, 32'h0000_0040, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b00, 2'b11, `CV_KEY_3, 1'b1, `CV_KEY_STAR, 1'b1);
                add_row("kp_9_star_number", 32'h0002_0040, 32'h0000_0080, 1'b0, 1'b0, 8'h00,
                        1'b0, 2'b00, 2'b11, `CV_KEY_9, 1'b1, `CV_KEY_NUMBER, 1'b1);
                add_row("kp_purple_blue", 32'h000C_0000, 32'h0008_0000, 1'b0, 1'b0, 8'h00,
                        1'b0, 2'b00, 2'b11, `CV_KEY_PURPLE, 1'b1, `CV_KEY_BLUE, 1'b1);
                add_row("kp_fire2", 32'h0000_0020, 32'h0000_0010, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b0, `CV_KEY_NONE, 1'b1);
                add_row("kp_key0_dirs", 32'h0000_0108, 32'h0000_0600, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b00, 2'b11, `CV_KEY_0, 1'b1, `CV_KEY_1, 1'b1);
                add_row("js_up_fire1", 32'h0000_0018, 32'h0000_0003, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b11, 2'b00, 4'b0111, 1'b0, 4'b1010, 1'b1);
                add_row("js_keys_ignored", 32'h0000_2004, 32'h0000_0020, 1'b0, 1'b0, 8'h00,
                        1'b0, 2'b11, 2'b00, 4'b1101, 1'b1, 4'b1111, 1'b1);
                add_row("both_sel_and", 32'h0000_1028, 32'h0001_0011, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b00, 2'b00, 4'b0001, 1'b0, 4'b1000, 1'b0);
                add_row("mixed_sel", 32'h0000_8800, 32'h0000_0018, 1'b0, 1'b0, 8'h00, 1'b0,
                        2'b10, 2'b01, `CV_KEY_3, 1'b1, 4'b0111, 1'b0);
                add_row("swap_keypad", 32'h0000_8800, 32'h0008_0000, 1'b1, 1'b0, 8'h00, 1'b0,
                        2'b00, 2'b11, `CV_KEY_BLUE, 1'b1, `CV_KEY_3, 1'b1);
                add_row("swap_joystick", 32'h0000_0018, 32'h0000_0003, 1'b1, 1'b0, 8'h00, 1'b0,
                        2'b11, 2'b00, 4'b1010, 1'b1, 4'b0111, 1'b0);
                // Keyboard rows, latches carry over from row to row
                add_row("ps2_pad5_press", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_5, 1'b1,
                        2'b00, 2'b11, `CV_KEY_5, 1'b1, `CV_KEY_5, 1'b1);
                add_row("ps2_unlisted", 32'h0, 32'h0, 1'b0, 1'b1, 8'h1C, 1'b1,
                        2'b00, 2'b11, `CV_KEY_5, 1'b1, `CV_KEY_5, 1'b1);
                add_row("ps2_pad5_release", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_5, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("ps2_shift_press", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_LSHIFT, 1'b1,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                // Shift still held, so 8 is the star key
                add_row("ps2_shift_8", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_8, 1'b1,
                        2'b00, 2'b11, `CV_KEY_STAR, 1'b1, `CV_KEY_STAR, 1'b1);
                add_row("ps2_8_release", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_8, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("ps2_shift_3", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_3, 1'b1,
                        2'b00, 2'b11, `CV_KEY_NUMBER, 1'b1, `CV_KEY_NUMBER, 1'b1);
                add_row("ps2_3_release", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_3, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("ps2_shift_release", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_LSHIFT, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("ps2_pad_star", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_STAR, 1'b1,
                        2'b00, 2'b11, `CV_KEY_STAR, 1'b1, `CV_KEY_STAR, 1'b1);
                add_row("ps2_star_release", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_STAR, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("ps2_pad_minus", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_MINUS, 1'b1,
                        2'b00, 2'b11, `CV_KEY_NUMBER, 1'b1, `CV_KEY_NUMBER, 1'b1);
                add_row("ps2_minus_release", 32'h0, 32'h0, 1'b0, 1'b1, `CV_PS2_PAD_MINUS, 1'b0,
                        2'b00, 2'b11, `CV_KEY_NONE, 1'b1, `CV_KEY_NONE, 1'b1);
                add_row("ps2_top5_merge", 32'h0000_0400, 32'h0, 1'b0, 1'b1, `CV_PS2_5, 1'b1,
                        2'b00, 2'b11, `CV_KEY_2, 1'b1, `CV_KEY_5, 1'b1);
                add_row("ps2_top5_release", 32'h0000_0400, 32'h0, 1'b0, 1'b1, `CV_PS2_5, 1'b0,
                        2'b00, 2'b11, `CV_KEY_2, 1'b1, `CV_KEY_NONE, 1'b1);
        endtask

        // ==============================
        // Drive and check
        // ==============================
        task automatic apply_row(input row_t r);
                joy0_i     = r.joy0;
                joy1_i     = r.joy1;
                swap_i     = r.swap;
                kp_sel_n_i = r.kp_n;
                js_sel_n_i = r.js_n;
                if (r.ev) begin
                        // One toggle flip is one key event
                        ps2_tog           = ~ps2_tog;
                        ps2_key_i.toggle  = ps2_tog;
                        ps2_key_i.pressed = r.press;
                        ps2_key_i.ext     = 1'b0;
                        ps2_key_i.code    = r.code;
                end
        endtask

        task automatic check_lines(input string name, input string what,
                                   input logic [3:0] exp, input logic [3:0] act);
                checks++;
                assert (act === exp) else begin
                        errors++;
                        $display("[ERROR] %s: %s expected %b, actual %b", name, what, exp, act);
                end
        endtask

        task automatic check_fire(input string name, input string what,
                                  input logic exp, input logic act);
                checks++;
                assert (act === exp) else begin
                        errors++;
                        $display("[ERROR] %s: %s expected %b, actual %b", name, what, exp, act);
                end
        endtask

        initial begin
                int wait_cnt;
                errors     = 0;
                checks     = 0;
                seed       = 30598;
                ps2_tog    = 1'b0;
                joy0_i     = '0;
                joy1_i     = '0;
                swap_i     = 1'b0;
                ps2_key_i  = '0;
                kp_sel_n_i = 2'b11;
                js_sel_n_i = 2'b11;
                build_table();
                add_random_rows(16);
                wait_cnt = 0;
                while (rst_n_i !== 1'b1 && wait_cnt < 40) begin
                        @(posedge clk_sys);
                        wait_cnt++;
                end
                if (rst_n_i !== 1'b1) begin
                        $display("Reset was not released within 40 clock cycles");
                        $display("Some tests failed");
                        $finish;
                end else begin
                        @(negedge clk_sys);
                        for (int i = 0; i < rows.size(); i++) begin
                                apply_row(rows[i]);
                                repeat (2) @(posedge clk_sys);
                                @(negedge clk_sys);
                                check_lines(names[i], "pad0 lines", rows[i].lines0, pad0_lines_o);
                                check_fire(names[i], "pad0 fire", rows[i].fire0, pad0_fire_n_o);
                                check_lines(names[i], "pad1 lines", rows[i].lines1, pad1_lines_o);
                                check_fire(names[i], "pad1 fire", rows[i].fire1, pad1_fire_n_o);
                        end
                        $display("Checks run: %0d, errors: %0d", checks, errors);
                        if (errors == 0) begin
                                $display("All tests passed");
                        end else begin
                                $display("Some tests failed");
                        end
                        $finish;
                end
        end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the controller-input testbench with Verilator and run it.
# Exits 0 only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module cv_ctrl_tb -f vlog.f -o cv_ctrl_sim \
        && ./obj_dir/cv_ctrl_sim > sim.log 2>&1 \
        || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && exit 0 || exit 1

//--- src/cv_ctrl_encoder.sv
// Controller port encoder for one player.
// Merges the player's keypad vector with the keyboard one and drives the
// port data lines and fire line from the console's select strobes.
// Purely combinational; the strobes act in the same cycle.

`include "cv_ctrl_macros.svh"

module cv_ctrl_encoder (
        input  cv_ctrl_pkg::keypad_vec_t pad_vec_i,
        input  cv_ctrl_pkg::keypad_vec_t kbd_vec_i,
        input  logic                     kp_sel_n_i,
        input  logic                     js_sel_n_i,
        output cv_ctrl_pkg::port_lines_t lines_o,
        output logic                     fire_n_o
);

        cv_ctrl_pkg::keypad_vec_t  vec;
        cv_ctrl_pkg::port_lines_t  kp_code;
        cv_ctrl_pkg::port_lines_t  kp_lines;
        cv_ctrl_pkg::port_lines_t  js_lines;
        logic                      kp_fire_n;
        logic                      js_fire_n;

        // Port code of keypad entry idx
        function automatic cv_ctrl_pkg::port_lines_t key_code(input int idx);
                case (idx)
                0:       return `CV_KEY_0;
                1:       return `CV_KEY_1;
                2:       return `CV_KEY_2;
                3:       return `CV_KEY_3;
                4:       return `CV_KEY_4;
                5:       return `CV_KEY_5;
                6:       return `CV_KEY_6;
                7:       return `CV_KEY_7;
                8:       return `CV_KEY_8;
                9:       return `CV_KEY_9;
                10:      return `CV_KEY_STAR;
                11:      return `CV_KEY_NUMBER;
                12:      return `CV_KEY_PURPLE;
                13:      return `CV_KEY_BLUE;
                default: return `CV_KEY_NONE;
                endcase
        endfunction

        assign vec = pad_vec_i | kbd_vec_i;

        // ==============================
        // Keypad half
        // ==============================
        always_comb begin
                kp_code = `CV_KEY_NONE;
                // Walk downwards so the lowest active entry wins
                for (int i = `CV_KEYPAD_KEYS - 1; i >= 0; i--) begin
                        if (vec[i]) begin
                                kp_code = key_code(i);
                        end
                end
                kp_lines  = kp_sel_n_i ? `CV_KEY_NONE : kp_code;
                kp_fire_n = kp_sel_n_i | ~vec[`CV_VEC_FIRE2];
        end

        // ==============================
        // Joystick half
        // ==============================
        always_comb begin
                js_lines  = 4'b1111;
                js_fire_n = 1'b1;
                if (!js_sel_n_i) begin
                        // Up on line 3 down to left on line 0
                        js_lines  = ~{vec[`CV_VEC_UP], vec[`CV_VEC_RIGHT],
                                      vec[`CV_VEC_DOWN], vec[`CV_VEC_LEFT]};
                        js_fire_n = ~vec[`CV_VEC_FIRE1];
                end
        end

        // Open-collector style wired AND of both halves
        assign lines_o  = kp_lines & js_lines;
        assign fire_n_o = kp_fire_n & js_fire_n;

endmodule

//--- src/cv_ctrl_macros.svh
// Constants shared by the controller-input RTL and its testbench.
// Holds the console port codes, the PS/2 scan codes of the emulated
// keypad and the fixed entry positions of the keypad vector.
// Include this file wherever one of these names is needed.

`ifndef CV_CTRL_MACROS_SVH
`define CV_CTRL_MACROS_SVH

// ==============================
// Console keypad port codes
// ==============================
`define CV_KEY_0        4'b0011
`define CV_KEY_1        4'b1110
`define CV_KEY_2        4'b1101
`define CV_KEY_3        4'b0110
`define CV_KEY_4        4'b0001
`define CV_KEY_5        4'b1001
`define CV_KEY_6        4'b0111
`define CV_KEY_7        4'b1100
`define CV_KEY_8        4'b1000
`define CV_KEY_9        4'b1011
`define CV_KEY_STAR     4'b1010
`define CV_KEY_NUMBER   4'b0101
`define CV_KEY_PURPLE   4'b0100
`define CV_KEY_BLUE     4'b0010
`define CV_KEY_NONE     4'b1111

// ==============================
// PS/2 scan codes, extended bit ignored
// ==============================
`define CV_PS2_0        8'h45
`define CV_PS2_1        8'h16
`define CV_PS2_2        8'h1E
`define CV_PS2_3        8'h26
`define CV_PS2_4        8'h25
`define CV_PS2_5        8'h2E
`define CV_PS2_6        8'h36
`define CV_PS2_7        8'h3D
`define CV_PS2_8        8'h3E
`define CV_PS2_9        8'h46
`define CV_PS2_PAD_0    8'h70
`define CV_PS2_PAD_1    8'h69
`define CV_PS2_PAD_2    8'h72
`define CV_PS2_PAD_3    8'h7A
`define CV_PS2_PAD_4    8'h6B
`define CV_PS2_PAD_5    8'h73
`define CV_PS2_PAD_6    8'h74
`define CV_PS2_PAD_7    8'h6C
`define CV_PS2_PAD_8    8'h75
`define CV_PS2_PAD_9    8'h7D
`define CV_PS2_PAD_STAR 8'h7C
`define CV_PS2_PAD_MINUS 8'h7B
`define CV_PS2_LSHIFT   8'h12
`define CV_PS2_RSHIFT   8'h59

// ==============================
// Keypad vector positions
// ==============================
// Entries 0..13 take part in the keypad priority encoding
`define CV_KEYPAD_KEYS  14
`define CV_VEC_STAR     10
`define CV_VEC_NUMBER   11
`define CV_VEC_UP       14
`define CV_VEC_RIGHT    15
`define CV_VEC_DOWN     16
`define CV_VEC_LEFT     17
`define CV_VEC_FIRE1    18
`define CV_VEC_FIRE2    19

`endif

//--- src/cv_ctrl_pkg.sv
// Data types of the controller-input path.
// Referenced by scoped name from every RTL module and the testbench.

package cv_ctrl_pkg;

        // Host joystick word
        //   0 right, 1 left, 2 down, 3 up
        //   4 fire 1, 5 fire 2, 6 star, 7 number
        //   8..17 keys 0..9, 18 purple, 19 blue
        //   20..31 not used by the console
        typedef logic [31:0] joy_word_t;

        // Keypad vector, entry 0 is the MSB
        //   0..9 keys 0..9, 10 star, 11 number, 12 purple, 13 blue
        //   14 up, 15 right, 16 down, 17 left, 18 fire 1, 19 fire 2
        typedef logic [0:19] keypad_vec_t;

        // Four controller data lines, active low
        typedef logic [3:0] port_lines_t;

        // PS/2 key word from the host
        typedef struct packed {
                // Flips once per key event
                logic       toggle;
                // 1 on make, 0 on break
                logic       pressed;
                // Extended (E0) prefix seen
                logic       ext;
                logic [7:0] code;
        } ps2_key_t;

endpackage

//--- src/cv_ctrl_top.sv
// Controller-input top level of the console.
// Captures the two host joysticks and the PS/2 keypad emulation and
// presents both game controller ports to the console, which selects
// the keypad or joystick half with its active-low strobes.

module cv_ctrl_top (
        input  logic                     clk_sys,
        input  logic                     rst_n_i,
        input  cv_ctrl_pkg::joy_word_t   joy0_i,
        input  cv_ctrl_pkg::joy_word_t   joy1_i,
        input  logic                     swap_i,
        input  cv_ctrl_pkg::ps2_key_t    ps2_key_i,
        input  logic [1:0]               kp_sel_n_i,
        input  logic [1:0]               js_sel_n_i,
        output cv_ctrl_pkg::port_lines_t pad0_lines_o,
        output logic                     pad0_fire_n_o,
        output cv_ctrl_pkg::port_lines_t pad1_lines_o,
        output logic                     pad1_fire_n_o
);

        cv_ctrl_pkg::keypad_vec_t pad0_vec;
        cv_ctrl_pkg::keypad_vec_t pad1_vec;
        cv_ctrl_pkg::keypad_vec_t kbd_vec;

        // ==============================
        // Input capture
        // ==============================
        joy_input_stage u_joy (
                .clk_sys    (clk_sys),
                .rst_n_i    (rst_n_i),
                .joy0_i     (joy0_i),
                .joy1_i     (joy1_i),
                .swap_i     (swap_i),
                .pad0_vec_o (pad0_vec),
                .pad1_vec_o (pad1_vec)
        );

        // Keyboard keypad feeds both players
        ps2_keypad_emu u_kbd (
                .clk_sys   (clk_sys),
                .rst_n_i   (rst_n_i),
                .ps2_key_i (ps2_key_i),
                .kbd_vec_o (kbd_vec)
        );

        // ==============================
        // Port encoders
        // ==============================
        cv_ctrl_encoder u_enc0 (
                .pad_vec_i  (pad0_vec),
                .kbd_vec_i  (kbd_vec),
                .kp_sel_n_i (kp_sel_n_i[0]),
                .js_sel_n_i (js_sel_n_i[0]),
                .lines_o    (pad0_lines_o),
                .fire_n_o   (pad0_fire_n_o)
        );

        cv_ctrl_encoder u_enc1 (
                .pad_vec_i  (pad1_vec),
                .kbd_vec_i  (kbd_vec),
                .kp_sel_n_i (kp_sel_n_i[1]),
                .js_sel_n_i (js_sel_n_i[1]),
                .lines_o    (pad1_lines_o),
                .fire_n_o   (pad1_fire_n_o)
        );

endmodule

//--- src/joy_input_stage.sv
// Host joystick capture for both players.
// Applies the player swap, reorders each word into the keypad vector
// layout and registers the result, one clock from input to output.

`include "cv_ctrl_macros.svh"

module joy_input_stage (
        input  logic                     clk_sys,
        input  logic                     rst_n_i,
        input  cv_ctrl_pkg::joy_word_t   joy0_i,
        input  cv_ctrl_pkg::joy_word_t   joy1_i,
        input  logic                     swap_i,
        output cv_ctrl_pkg::keypad_vec_t pad0_vec_o,
        output cv_ctrl_pkg::keypad_vec_t pad1_vec_o
);

        cv_ctrl_pkg::joy_word_t joy_a;
        cv_ctrl_pkg::joy_word_t joy_b;

        // Host bit order to console keypad order
        function automatic cv_ctrl_pkg::keypad_vec_t to_keypad(
                input cv_ctrl_pkg::joy_word_t w
        );
                cv_ctrl_pkg::keypad_vec_t v;
                v = '0;
                for (int k = 0; k < 10; k++) begin
                        v[k] = w[8 + k];
                end
                v[`CV_VEC_STAR]   = w[6];
                v[`CV_VEC_NUMBER] = w[7];
                // Purple and blue triggers
                v[12] = w[18];
                v[13] = w[19];
                v[`CV_VEC_UP]     = w[3];
                v[`CV_VEC_RIGHT]  = w[0];
                v[`CV_VEC_DOWN]   = w[2];
                v[`CV_VEC_LEFT]   = w[1];
                v[`CV_VEC_FIRE1]  = w[4];
                v[`CV_VEC_FIRE2]  = w[5];
                return v;
        endfunction

        // Player swap
        assign joy_a = swap_i ? joy1_i : joy0_i;
        assign joy_b = swap_i ? joy0_i : joy1_i;

        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        pad0_vec_o <= '0;
                        pad1_vec_o <= '0;
                end else begin
                        pad0_vec_o <= to_keypad(joy_a);
                        pad1_vec_o <= to_keypad(joy_b);
                end
        end

endmodule

//--- src/ps2_keypad_emu.sv
// Numeric keypad emulation from the host PS/2 keyboard.
// Each flip of the event toggle updates one button latch; the latches
// are presented as a keypad vector that is merged into both players.
// Shift+8 stands for star and Shift+3 for number.

`include "cv_ctrl_macros.svh"

module ps2_keypad_emu (
        input  logic                   clk_sys,
        input  logic                   rst_n_i,
        input  cv_ctrl_pkg::ps2_key_t  ps2_key_i,
        output cv_ctrl_pkg::keypad_vec_t kbd_vec_o
);

        logic        toggle_q;
        logic        key_event;
        logic [0:9]  btn_digit;
        logic        btn_star;
        logic        btn_minus;
        logic        btn_shift;

        assign key_event = ps2_key_i.toggle != toggle_q;

        // ==============================
        // Button latches
        // ==============================
        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        toggle_q  <= 1'b0;
                        btn_digit <= '0;
                        btn_star  <= 1'b0;
                        btn_minus <= 1'b0;
                        btn_shift <= 1'b0;
                end else begin
                        toggle_q <= ps2_key_i.toggle;
                        if (key_event) begin
                                // Top row and numeric pad share the digit latches
                                case (ps2_key_i.code)
                                `CV_PS2_0, `CV_PS2_PAD_0: btn_digit[0] <= ps2_key_i.pressed;
                                `CV_PS2_1, `CV_PS2_PAD_1: btn_digit[1] <= ps2_key_i.pressed;
                                `CV_PS2_2, `CV_PS2_PAD_2: btn_digit[2] <= ps2_key_i.pressed;
                                `CV_PS2_3, `CV_PS2_PAD_3: btn_digit[3] <= ps2_key_i.pressed;
                                `CV_PS2_4, `CV_PS2_PAD_4: btn_digit[4] <= ps2_key_i.pressed;
                                `CV_PS2_5, `CV_PS2_PAD_5: btn_digit[5] <= ps2_key_i.pressed;
                                `CV_PS2_6, `CV_PS2_PAD_6: btn_digit[6] <= ps2_key_i.pressed;
                                `CV_PS2_7, `CV_PS2_PAD_7: btn_digit[7] <= ps2_key_i.pressed;
                                `CV_PS2_8, `CV_PS2_PAD_8: btn_digit[8] <= ps2_key_i.pressed;
                                `CV_PS2_9, `CV_PS2_PAD_9: btn_digit[9] <= ps2_key_i.pressed;
                                `CV_PS2_PAD_STAR:  btn_star  <= ps2_key_i.pressed;
                                `CV_PS2_PAD_MINUS: btn_minus <= ps2_key_i.pressed;
                                `CV_PS2_LSHIFT, `CV_PS2_RSHIFT: begin
                                        btn_shift <= ps2_key_i.pressed;
                                end
                                default: begin
                                        // Other keys leave the latches alone
                                end
                                endcase
                        end
                end
        end

        // ==============================
        // Keypad vector
        // ==============================
        always_comb begin
                kbd_vec_o = '0;
                kbd_vec_o[0:9] = btn_digit;
                // With shift held 8 and 3 stand for star and number only
                kbd_vec_o[3] = btn_digit[3] & ~btn_shift;
                kbd_vec_o[8] = btn_digit[8] & ~btn_shift;
                kbd_vec_o[`CV_VEC_STAR]   = btn_star | (btn_shift & btn_digit[8]);
                kbd_vec_o[`CV_VEC_NUMBER] = btn_minus | (btn_shift & btn_digit[3]);
        end

endmodule

//--- vlog.f
+incdir+src
src/cv_ctrl_pkg.sv
src/ps2_keypad_emu.sv
src/joy_input_stage.sv
src/cv_ctrl_encoder.sv
src/cv_ctrl_top.sv
bench/cv_ctrl_tb.sv
